/* src.f */
+incdir+tests
src/xb_pkg.sv
src/xb_fifo.sv
src/host_msg_parser.sv
src/pulse_sampler.sv
src/rd_word_splitter.sv
src/xb_stream_top.sv
tests/tb_xb_stream.sv

/* Makefile */
BIN := obj_dir/Vtb_xb_stream
SRCS := src.f $(wildcard src/*.sv tests/*.sv tests/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS)
	verilator --binary --assert -j 0 --top-module tb_xb_stream -f src.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir

/* tests/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

  // every sample the host should see, in order, across all runs
  xb_pkg::fpga_msg_t exp_q[$];

  // a start clears the accumulator, so sample n carries (n+1) steps
  task automatic push_run(input logic [15:0] count, input logic [31:0] step);
    xb_pkg::fpga_msg_t m;
    for (int n = 0; n < int'(count); n++) begin
      m.seq = n;
      m.value = 32'(n + 1) * step;  // wraps modulo 2**32
      exp_q.push_back(m);
    end
  endtask

  task automatic check_word(input string name, input xb_pkg::xb_word_t got,
                            input xb_pkg::xb_word_t want);
    if (got !== want) begin
      $display("ERROR %0t %s got %h expected %h", $time, name, got, want);
      stop_on_error();
    end
  endtask

  task automatic check_msg(input string name, input xb_pkg::fpga_msg_t got,
                           input xb_pkg::fpga_msg_t want);
    if (got !== want) begin
      $display("ERROR %0t %s got seq %0d value %h expected seq %0d value %h",
               $time, name, got.seq, got.value, want.seq, want.value);
      stop_on_error();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("ERROR %0t %s got %b expected %b", $time, name, got, want);
      stop_on_error();
    end
  endtask

`endif

/* tests/tb_xb_stream.sv */
`default_nettype none

module tb_xb_stream;

  logic BUS_CLK = 1'b0;
  logic reset;
  logic wr_wren;
  xb_pkg::xb_word_t wr_data;
  logic wr_open;
  logic wr_full;
  logic rd_rden;
  logic rd_open;
  xb_pkg::xb_word_t rd_data;
  logic rd_empty;
  logic rd_eof;
  logic app_running;
  logic app_error;

  int unsigned cycles;  // edges seen by the stimulus
  int unsigned limit;  // grows with every run sent
  int unsigned rd_pct;  // chance of rd_rden per cycle, percent
  int unsigned gap_max;  // idle cycles between written words
  int unsigned skipped;  // model entries dropped after a stop
  int unsigned rx_count = 0;  // pairs read back so far
  logic lo_seen = 1'b0;
  xb_pkg::xb_word_t lo_word;

  xb_stream_top #(.WR_DEPTH(16), .RD_DEPTH(8), .AF_MARGIN(2)) uut (
    .BUS_CLK(BUS_CLK), .reset(reset),
    .wr_wren(wr_wren), .wr_data(wr_data), .wr_open(wr_open), .wr_full(wr_full),
    .rd_rden(rd_rden), .rd_open(rd_open), .rd_data(rd_data),
    .rd_empty(rd_empty), .rd_eof(rd_eof),
    .app_running(app_running), .app_error(app_error)
  );

  always #20 BUS_CLK = ~BUS_CLK;

  task automatic stop_on_error();
    $display("Some tests failed");
    $fatal(1, "stopped at the first failing check");
  endtask

  `include "tb_model.svh"

  task automatic tick();
    @(posedge BUS_CLK);
    cycles++;
    wr_wren <= 1'b0;  // a sender overrides this after the call
    rd_rden <= (($urandom % 100) < rd_pct);
    if (cycles > limit) begin
      $display("timeout: run still busy after %0d cycles", cycles);
      stop_on_error();
    end
  endtask

  task automatic send_word(input xb_pkg::xb_word_t w);
    logic room;
    int unsigned gap;
    room = 1'b0;
    while (!room) begin
      @(negedge BUS_CLK);
      room = !wr_full;  // early full leaves room for the word in flight
      tick();
      if (room) begin
        wr_wren <= 1'b1;
        wr_data <= w;
      end
    end
    gap = $urandom % (gap_max + 1);
    repeat (gap) tick();
  endtask

  task automatic send_msg(input xb_pkg::xb_word_t w0, input xb_pkg::xb_word_t w1,
                          input xb_pkg::xb_word_t w2);
    send_word(w0);
    send_word(w1);
    send_word(w2);
  endtask

  // unused halves get random junk
  task automatic send_start(input logic [15:0] count, input logic [15:0] interval,
                            input logic [31:0] step);
    push_run(count, step);
    limit += 40 * int'(count) * int'((interval == 16'd0) ? 16'd1 : interval);
    send_msg({16'($urandom), count}, {interval, 16'($urandom)}, step);
  endtask

  task automatic wait_eof();
    logic seen;
    seen = 1'b0;
    while (!seen) begin
      @(negedge BUS_CLK);
      seen = rd_eof;
      tick();
    end
  endtask

  task automatic drain();
    while (rx_count + skipped != exp_q.size()) tick();
    wait_eof();
  endtask

  task automatic check_status(input logic running, input logic error);
    @(negedge BUS_CLK);
    check_flag("app_running", app_running, running);
    check_flag("app_error", app_error, error);
    tick();
  endtask

  // a word is taken at the next rising edge when rden is high and data is there
  always @(negedge BUS_CLK) begin : rd_monitor
    xb_pkg::fpga_msg_t want;
    if (!reset && rd_rden && rd_open && !rd_empty) begin
      if (rx_count + skipped >= exp_q.size()) begin
        $display("unexpected word on the read stream at time %0t", $time);
        stop_on_error();
      end
      want = exp_q[rx_count + skipped];
      if (!lo_seen) begin
        check_word("rd_data", rd_data, want.seq);  // seq comes first
        lo_word = rd_data;
        lo_seen = 1'b1;
      end else begin
        check_msg("rd_data pair", {rd_data, lo_word}, want);
        lo_seen = 1'b0;
        rx_count++;
      end
    end
  end

  initial begin
    int unsigned base;
    logic seen;
    reset <= 1'b1;
    wr_wren <= 1'b0;
    wr_data <= '0;
    wr_open <= 1'b0;
    rd_rden <= 1'b0;
    rd_open <= 1'b0;
    cycles = 0;
    limit = 2000;
    rd_pct = 50;
    gap_max = 3;
    skipped = 0;
    void'($urandom(32));
    repeat (3) tick();
    reset <= 1'b0;
    wr_open <= 1'b1;
    rd_open <= 1'b1;
    @(negedge BUS_CLK);
    check_flag("wr_full", wr_full, 1'b0);
    check_flag("rd_empty", rd_empty, 1'b1);
    check_flag("rd_eof", rd_eof, 1'b0);
    check_status(1'b0, 1'b0);

    repeat (10) begin
      send_start(16'(1 + $urandom % 20), 16'($urandom % 6), $urandom);
      drain();
      check_status(1'b0, 1'b0);
    end

    rd_pct = 10;  // slow reader, sampler has to stall
    send_start(16'd30, 16'd0, $urandom);
    drain();
    check_status(1'b0, 1'b0);

    rd_pct = 50;
    base = rx_count;
    send_start(16'd1000, 16'd3, $urandom);
    while (rx_count < base + 10) tick();
    send_msg('0, '0, '0);  // all zero words
    wait_eof();
    if (rx_count - base >= 1000) begin
      $display("stop message did not end the long run early");
      stop_on_error();
    end
    check_status(1'b0, 1'b0);
    skipped = exp_q.size() - rx_count;  // rest of that run never comes

    send_msg({16'($urandom | 1), 16'h0000}, $urandom, $urandom);  // zero count
    seen = 1'b0;
    while (!seen) begin
      @(negedge BUS_CLK);
      seen = app_error;
      tick();
    end
    check_status(1'b0, 1'b1);
    send_start(16'(1 + $urandom % 20), 16'($urandom % 6), $urandom);
    drain();
    check_status(1'b0, 1'b0);

    rd_pct = 100;
    gap_max = 0;
    for (int i = 0; i < 7; i++) begin
      send_start(16'(1 + i % 2), 16'd0, $urandom);  // short runs end before the next
    end
    send_start(16'(1 + $urandom % 20), 16'($urandom % 6), $urandom);
    drain();
    check_status(1'b0, 1'b0);

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* src/xb_stream_top.sv */
`default_nettype none

module xb_stream_top #(
  parameter int WR_DEPTH = 16,
  parameter int RD_DEPTH = 8,
  parameter int AF_MARGIN = 2
) (
  input wire BUS_CLK,
  input wire reset,
  input wire wr_wren,
  input wire xb_pkg::xb_word_t wr_data,
  input wire wr_open,
  output logic wr_full,
  input wire rd_rden,
  input wire rd_open,
  output xb_pkg::xb_word_t rd_data,
  output logic rd_empty,
  output logic rd_eof,
  output logic app_running,
  output logic app_error
);

  xb_pkg::xb_word_t wr_word;  // wr_fifo -> parser
  logic wr_word_empty;
  logic wr_word_rden;
  logic cmd_valid;  // parser -> sampler
  xb_pkg::host_cmd_t cmd;
  logic msg_wren;  // sampler -> rd_fifo
  logic msg_full;
  xb_pkg::fpga_msg_t msg_in;
  xb_pkg::fpga_msg_t msg_out;  // rd_fifo -> splitter
  logic msg_empty;
  logic msg_rden;
  logic run_done;

  xb_fifo #(
    .T(xb_pkg::xb_word_t),
    .DEPTH(WR_DEPTH),
    .AF_MARGIN(AF_MARGIN)
  ) wr_fifo (
    .BUS_CLK(BUS_CLK),
    .reset(reset),
    .wren(wr_wren && wr_open),  // closed stream writes nothing
    .din(wr_data),
    .full(),
    .almost_full(wr_full),  // host sees early full
    .rden(wr_word_rden),
    .dout(wr_word),
    .empty(wr_word_empty)
  );

  host_msg_parser parser (
    .BUS_CLK(BUS_CLK),
    .reset(reset),
    .word(wr_word),
    .word_empty(wr_word_empty),
    .word_rden(wr_word_rden),
    .cmd_valid(cmd_valid),
    .cmd(cmd)
  );

  pulse_sampler sampler (
    .BUS_CLK(BUS_CLK),
    .reset(reset),
    .cmd_valid(cmd_valid),
    .cmd(cmd),
    .msg_full(msg_full),
    .msg_wren(msg_wren),
    .msg(msg_in),
    .app_running(app_running),
    .app_error(app_error),
    .run_done(run_done)
  );

  xb_fifo #(
    .T(xb_pkg::fpga_msg_t),
    .DEPTH(RD_DEPTH),
    .AF_MARGIN(AF_MARGIN)
  ) rd_fifo (
    .BUS_CLK(BUS_CLK),
    .reset(reset),
    .wren(msg_wren),
    .din(msg_in),
    .full(msg_full),
    .almost_full(),
    .rden(msg_rden),
    .dout(msg_out),
    .empty(msg_empty)
  );

  rd_word_splitter splitter (
    .BUS_CLK(BUS_CLK),
    .reset(reset),
    .msg(msg_out),
    .msg_empty(msg_empty),
    .msg_rden(msg_rden),
    .run_done(run_done),
    .app_running(app_running),
    .rd_rden(rd_rden && rd_open),  // reads count only while open
    .rd_data(rd_data),
    .rd_empty(rd_empty),
    .rd_eof(rd_eof)
  );

endmodule

`default_nettype wire

/* src/rd_word_splitter.sv */
`default_nettype none

module rd_word_splitter (
  input wire BUS_CLK,
  input wire reset,
  input wire xb_pkg::fpga_msg_t msg,
  input wire msg_empty,
  output logic msg_rden,
  input wire run_done,
  input wire app_running,
  input wire rd_rden,
  output xb_pkg::xb_word_t rd_data,
  output logic rd_empty,
  output logic rd_eof
);

  logic half;  // 0 low word, 1 high word
  logic take;  // host accepted the word on offer

  assign take = rd_rden && !msg_empty;  // reads on an empty stream are ignored

  assign rd_data = half ? msg.value : msg.seq;
  assign rd_empty = msg_empty;

  // release the FIFO entry only once both halves are gone
  assign msg_rden = take && half;

  // end of file once the run is over and everything was read
  assign rd_eof = run_done && !app_running && msg_empty;

  always_ff @(posedge BUS_CLK) begin
    if (reset) begin
      half <= 1'b0;
    end else if (take) begin
      half <= !half;
    end
  end

endmodule

`default_nettype wire

/* src/pulse_sampler.sv */
`default_nettype none

module pulse_sampler (
  input wire BUS_CLK,
  input wire reset,
  input wire cmd_valid,
  input wire xb_pkg::host_cmd_t cmd,
  input wire msg_full,
  output logic msg_wren,
  output xb_pkg::fpga_msg_t msg,
  output logic app_running,
  output logic app_error,
  output logic run_done
);

  logic running;
  logic [15:0] remaining;  // samples still to write
  logic [15:0] ivl_cnt;  // cycles until the next sample may go
  logic [15:0] ivl_len;  // interval, zero raised to one
  logic [31:0] step_r;
  xb_pkg::fpga_msg_t cur;  // pending sample, value already includes step
  logic is_start;
  logic is_stop;
  logic is_bad;

  assign is_start = cmd_valid && (cmd.kind == xb_pkg::CMD_START);
  assign is_stop = cmd_valid && (cmd.kind == xb_pkg::CMD_STOP);
  assign is_bad = cmd_valid && (cmd.kind == xb_pkg::CMD_BAD);

  // stall rather than drop when the read FIFO fills
  assign msg_wren = running && (ivl_cnt == '0) && !msg_full;
  assign msg = cur;
  assign app_running = running;

  always_ff @(posedge BUS_CLK) begin
    if (reset) begin
      running <= 1'b0;
      remaining <= '0;
      ivl_cnt <= '0;
      app_error <= 1'b0;
      run_done <= 1'b0;
    end else if (is_start) begin
      running <= 1'b1;
      remaining <= cmd.count;
      ivl_cnt <= '0;  // first sample on the next cycle
      app_error <= 1'b0;
      run_done <= 1'b0;
    end else if (is_stop) begin
      running <= 1'b0;
      run_done <= 1'b1;
    end else begin
      if (is_bad) begin
        app_error <= 1'b1;  // run in progress carries on
      end
      if (msg_wren) begin
        remaining <= remaining - 1'b1;
        ivl_cnt <= ivl_len - 1'b1;
        if (remaining == 16'd1) begin
          running <= 1'b0;
          run_done <= 1'b1;
        end
      end else if (running && (ivl_cnt != '0) && !msg_full) begin
        ivl_cnt <= ivl_cnt - 1'b1;  // frozen under back-pressure
      end
    end
  end

  // sample payload and run settings
  always_ff @(posedge BUS_CLK) begin
    if (is_start) begin
      cur.seq <= '0;
      cur.value <= cmd.step;  // cleared accumulator plus one step
      step_r <= cmd.step;
      ivl_len <= (cmd.interval == '0) ? 16'd1 : cmd.interval;
    end else if (msg_wren) begin
      cur.seq <= cur.seq + 1'b1;
      cur.value <= cur.value + step_r;
    end
  end

  a_no_write_full: assert property (
    @(posedge BUS_CLK) disable iff (reset) msg_wren |-> !msg_full
  ) else $error("pulse_sampler: write while read FIFO full");

endmodule

`default_nettype wire

/* src/host_msg_parser.sv */
`default_nettype none

module host_msg_parser (
  input wire BUS_CLK,
  input wire reset,
  input wire xb_pkg::xb_word_t word,
  input wire word_empty,
  output logic word_rden,
  output logic cmd_valid,
  output xb_pkg::host_cmd_t cmd
);

  logic [1:0] word_cnt;  // which word of the message is next
  logic zero_acc;  // every word so far was zero
  logic last_zero;
  logic last_word;

  // fall-through FIFO, so pop whatever is there
  assign word_rden = !word_empty;

  assign last_zero = zero_acc && (word == '0);
  assign last_word = (word_cnt == 2'(xb_pkg::MSG_WORDS - 1));

  always_ff @(posedge BUS_CLK) begin
    if (reset) begin
      word_cnt <= '0;
      cmd_valid <= 1'b0;
    end else begin
      cmd_valid <= 1'b0;
      if (word_rden) begin
        if (last_word) begin
          word_cnt <= '0;
          cmd_valid <= 1'b1;  // one cycle after the third pop
        end else begin
          word_cnt <= word_cnt + 1'b1;
        end
      end
    end
  end

  // steer each popped word into its field
  always_ff @(posedge BUS_CLK) begin
    if (word_rden) begin
      case (word_cnt)
        2'(xb_pkg::COUNT_IDX): begin
          cmd.count <= word[15:0];
          zero_acc <= (word == '0);  // first word starts the check
        end
        2'(xb_pkg::INTERVAL_IDX): begin
          cmd.interval <= word[31:16];
          zero_acc <= last_zero;
        end
        2'(xb_pkg::STEP_IDX): begin
          cmd.step <= word;
          if (last_zero) begin
            cmd.kind <= xb_pkg::CMD_STOP;
          end else if (cmd.count != '0) begin
            cmd.kind <= xb_pkg::CMD_START;
          end else begin
            cmd.kind <= xb_pkg::CMD_BAD;  // zero count but not a stop
          end
        end
        default: begin
          zero_acc <= zero_acc;
        end
      endcase
    end
  end

  a_cmd_pulse: assert property (
    @(posedge BUS_CLK) disable iff (reset) cmd_valid |=> !cmd_valid
  ) else $error("host_msg_parser: cmd_valid held for two cycles");

endmodule

`default_nettype wire

/* src/xb_fifo.sv */
`default_nettype none

module xb_fifo #(
  parameter type T = logic [31:0],
  parameter int DEPTH = 16,
  parameter int AF_MARGIN = 2
) (
  input wire BUS_CLK,
  input wire reset,
  input wire wren,
  input wire T din,
  output logic full,
  output logic almost_full,
  input wire rden,
  output T dout,
  output logic empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T mem [DEPTH];  // storage only, no reset
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;  // occupancy
  logic do_wr;
  logic do_rd;

  assign do_wr = wren && !full;  // strobes outside the rules are dropped
  assign do_rd = rden && !empty;

  assign full = (count == CNT_W'(DEPTH));
  assign almost_full = (count >= CNT_W'(DEPTH - AF_MARGIN));  // AF_MARGIN or fewer free
  assign empty = (count == '0);
  assign dout = mem[rd_ptr];  // fall-through, oldest entry always visible

  always_ff @(posedge BUS_CLK) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge BUS_CLK) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // wrap for any depth
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10: begin
          count <= count + 1'b1;
        end
        2'b01: begin
          count <= count - 1'b1;
        end
        default: begin
          count <= count;  // idle, or push and pop together
        end
      endcase
    end
  end

  // the producer must honour full, the consumer must honour empty
  a_no_write_full: assert property (
    @(posedge BUS_CLK) disable iff (reset) wren |-> !full
  ) else $error("xb_fifo: write while full");

  a_no_read_empty: assert property (
    @(posedge BUS_CLK) disable iff (reset) rden |-> !empty
  ) else $error("xb_fifo: read while empty");

endmodule

`default_nettype wire

/* src/xb_pkg.sv */
`default_nettype none

package xb_pkg;

  localparam int WORD_W = 32;  // host stream width
  localparam int MSG_WORDS = 3;  // words per host message

  // position of each field's word within a host message
  localparam int COUNT_IDX = 0;
  localparam int INTERVAL_IDX = 1;
  localparam int STEP_IDX = 2;

  typedef logic [WORD_W-1:0] xb_word_t;

  typedef enum logic [1:0] {
    CMD_START = 2'd0,
    CMD_STOP = 2'd1,
    CMD_BAD = 2'd2
  } cmd_kind_t;

  // value sits in the upper half, so seq is the low word on the read stream
  typedef struct packed {
    logic [31:0] value;  // accumulated sample value
    logic [31:0] seq;  // sample index within the run
  } fpga_msg_t;

  typedef struct packed {
    cmd_kind_t kind;
    logic [15:0] count;  // low half of word 0
    logic [15:0] interval;  // high half of word 1
    logic [31:0] step;  // all of word 2
  } host_cmd_t;

endpackage

`default_nettype wire
